//--- logic/bios_word_packer.sv
// BIOS word packer
// Pairs host halfwords into 32 bit writes for the boot ROM memory

`timescale 1ns/10ps
`include "cart_loader_params.svh"

module bios_word_packer (
	input  logic                         clk_sys,
	input  logic                         reset,
	input  cart_loader_pkg::ioctl_bus_s  ioctl,
	input  cart_loader_pkg::dl_kind_e    dl_kind,
	output cart_loader_pkg::bios_write_s bios
);

	cart_loader_pkg::ioctl_data_t low_half;   // Held until the upper half arrives
	logic                         bios_wr_in;

	assign bios_wr_in = ioctl.wr && (dl_kind == cart_loader_pkg::DL_BIOS);

	always_ff @(posedge clk_sys) begin
		// Strobe on the upper half only
		if (reset) bios.wr <= 1'b0;
		else       bios.wr <= bios_wr_in && ioctl.addr[1];

		if (bios_wr_in) begin
			if (!ioctl.addr[1]) begin
				low_half <= ioctl.dout;
			end else begin
				bios.addr <= ioctl.addr[`CL_BIOS_ADDR_W+1:2];   // Byte to word address
				bios.data <= {ioctl.dout, low_half};
			end
		end
	end

endmodule

//--- logic/cart_loader_params.svh
// Cartridge loader constants
// Widths of the host stream and memories, ROM placement, header and signature

`ifndef CART_LOADER_PARAMS_SVH
`define CART_LOADER_PARAMS_SVH

// ==============================
// Bus widths
// ==============================
`define CL_ADDR_W       27      // Host byte address
`define CL_DATA_W       16      // Host data word
`define CL_BIOS_ADDR_W  12      // BIOS word address
`define CL_PAK_ADDR_W   25      // Cart dword address
`define CL_ROM_ADDR_W   26      // External memory halfword address

// ==============================
// Memory map and header layout
// ==============================
`define CL_ROM_START_HW 393216  // ROM area base in halfwords
`define CL_ID_LINE      10      // Header line 0xA0..0xAF
`define CL_ID_LEN       12      // Title bytes

// Save type marker searched in the image
`define CL_FLASH_SIG     "FLASH1M_V"
`define CL_FLASH_SIG_LEN 9

`endif

//--- logic/cart_loader_pkg.sv
// Cartridge loader types
// Vector typedefs, download kind and the bundled buses between blocks

`include "cart_loader_params.svh"

package cart_loader_pkg;

	typedef logic [`CL_ADDR_W-1:0]      ioctl_addr_t;   // Host byte address
	typedef logic [`CL_DATA_W-1:0]      ioctl_data_t;
	typedef logic [`CL_BIOS_ADDR_W-1:0] bios_addr_t;
	typedef logic [31:0]                word_t;
	typedef logic [`CL_PAK_ADDR_W-1:0]  pak_addr_t;     // Dword units
	typedef logic [`CL_ROM_ADDR_W-1:0]  rom_addr_t;     // Halfword units
	typedef logic [`CL_ID_LEN*8-1:0]    cart_id_t;      // First char in MSBs

	// What the host is currently sending
	typedef enum logic [1:0] {
		DL_NONE = 2'd0,
		DL_BIOS = 2'd1,
		DL_CART = 2'd2
	} dl_kind_e;

	typedef struct packed {
		ioctl_addr_t addr;
		ioctl_data_t dout;
		logic        wr;     // One cycle per halfword
	} ioctl_bus_s;

	typedef struct packed {
		bios_addr_t addr;
		word_t      data;
		logic       wr;
	} bios_write_s;

	typedef struct packed {
		rom_addr_t   addr;
		ioctl_data_t data;
		logic        req;    // Pulse, answered by rom_ack
	} rom_write_s;

	typedef struct packed {
		logic      flash_1m;
		logic      sram_quirk;
		logic      memory_remap;
		logic      force_turbo;
		pak_addr_t max_pak_addr;
	} cart_info_s;

endpackage

//--- logic/cart_loader_top.sv
// Cartridge loader top
// Connects the download decoder, BIOS packer, ROM port and cart scanners

`timescale 1ns/10ps

module cart_loader_top (
	input  logic                         clk_sys,
	input  logic                         reset,
	input  cart_loader_pkg::ioctl_bus_s  ioctl,
	input  logic                         ioctl_download,
	input  logic [7:0]                   ioctl_index,
	output logic                         ioctl_wait,
	output cart_loader_pkg::bios_write_s bios,
	output cart_loader_pkg::rom_write_s  rom,
	input  logic                         rom_ack,
	output cart_loader_pkg::cart_info_s  cart_info
);

	cart_loader_pkg::dl_kind_e  dl_kind;      // Shared by every block
	logic                       cart_start;
	logic                       flash_1m;
	logic                       sram_quirk;
	logic                       memory_remap;
	logic                       force_turbo;
	cart_loader_pkg::pak_addr_t max_pak_addr;

	download_decode u_decode (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_addr     (ioctl.addr),
		.dl_kind        (dl_kind),
		.cart_start     (cart_start),
		.max_pak_addr   (max_pak_addr),
		.force_turbo    (force_turbo)
	);

	bios_word_packer u_bios (.clk_sys(clk_sys), .reset(reset), .ioctl(ioctl),
		.dl_kind(dl_kind), .bios(bios));

	rom_write_port u_rom (.clk_sys(clk_sys), .reset(reset), .ioctl(ioctl),
		.dl_kind(dl_kind), .rom(rom), .rom_ack(rom_ack), .ioctl_wait(ioctl_wait));

	flash_sig_scan u_flash (.clk_sys(clk_sys), .reset(reset), .ioctl(ioctl),
		.dl_kind(dl_kind), .cart_start(cart_start), .flash_1m(flash_1m));

	quirk_match u_quirk (.clk_sys(clk_sys), .reset(reset), .ioctl(ioctl),
		.dl_kind(dl_kind), .cart_start(cart_start),
		.sram_quirk(sram_quirk), .memory_remap(memory_remap));

	// Cart properties handed on to the console core
	assign cart_info = '{
		flash_1m:     flash_1m,
		sram_quirk:   sram_quirk,
		memory_remap: memory_remap,
		force_turbo:  force_turbo,
		max_pak_addr: max_pak_addr
	};

endmodule

//--- logic/download_decode.sv
// Download classifier
// Registers the host download level, splits BIOS from cart by index,
// and keeps the end address and cart type of the last cart download

`timescale 1ns/10ps
`include "cart_loader_params.svh"

module download_decode (
	input  logic                       clk_sys,
	input  logic                       reset,
	input  logic                       ioctl_download,
	input  logic [7:0]                 ioctl_index,
	input  cart_loader_pkg::ioctl_addr_t ioctl_addr,
	output cart_loader_pkg::dl_kind_e  dl_kind,
	output logic                       cart_start,
	output cart_loader_pkg::pak_addr_t max_pak_addr,
	output logic                       force_turbo
);

	cart_loader_pkg::dl_kind_e kind_next;
	cart_loader_pkg::dl_kind_e kind_prev;   // dl_kind one cycle back
	logic                      cart_end;
	logic [1:0]                cart_type;

	// Index 0 is BIOS, all ones is a code file and ignored
	always_comb begin
		if (!ioctl_download)    kind_next = cart_loader_pkg::DL_NONE;
		else if (ioctl_index == 8'd0) kind_next = cart_loader_pkg::DL_BIOS;
		else if (&ioctl_index)  kind_next = cart_loader_pkg::DL_NONE;
		else                    kind_next = cart_loader_pkg::DL_CART;
	end

	assign cart_start = (dl_kind == cart_loader_pkg::DL_CART) &&
		(kind_prev != cart_loader_pkg::DL_CART);               // First cart cycle
	assign cart_end   = (kind_prev == cart_loader_pkg::DL_CART) &&
		(dl_kind != cart_loader_pkg::DL_CART);
	assign force_turbo = |cart_type;                           // Any nonzero type

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			dl_kind      <= cart_loader_pkg::DL_NONE;
			kind_prev    <= cart_loader_pkg::DL_NONE;
			max_pak_addr <= '0;
			cart_type    <= 2'd0;
		end else begin
			dl_kind   <= kind_next;
			kind_prev <= dl_kind;
			// Host still holds the final address here
			if (cart_end)   max_pak_addr <= ioctl_addr[`CL_ADDR_W-1:2];
			if (cart_start) cart_type    <= ioctl_index[7:6];
		end
	end

endmodule

//--- logic/flash_sig_scan.sv
// Flash size detector
// Slides the cart bytes through a window and looks for the 1M flash marker

`timescale 1ns/10ps
`include "cart_loader_params.svh"

module flash_sig_scan (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  cart_loader_pkg::ioctl_bus_s ioctl,
	input  cart_loader_pkg::dl_kind_e   dl_kind,
	input  logic                        cart_start,
	output logic                        flash_1m
);

	localparam int SIG_W = `CL_FLASH_SIG_LEN * 8;
	localparam int WIN_W = SIG_W - 8;                // All but the newest byte
	localparam logic [SIG_W-1:0] FLASH_SIG = `CL_FLASH_SIG;

	logic [WIN_W-1:0] sig_window;   // Oldest byte in the MSBs
	logic             cart_wr;
	logic             hit_lo;       // Marker ends on the low byte
	logic             hit_hi;       // Marker ends on the high byte

	assign cart_wr = ioctl.wr && (dl_kind == cart_loader_pkg::DL_CART);
	assign hit_lo  = {sig_window, ioctl.dout[7:0]} == FLASH_SIG;
	assign hit_hi  = {sig_window[WIN_W-9:0], ioctl.dout[7:0], ioctl.dout[15:8]} == FLASH_SIG;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			flash_1m <= 1'b0;
		end else if (cart_start) begin
			flash_1m <= 1'b0;                        // New image, forget old result
		end else if (cart_wr && (hit_lo || hit_hi)) begin
			flash_1m <= 1'b1;
		end

		// Low byte comes first in memory order
		if (cart_start)   sig_window <= '0;
		else if (cart_wr) sig_window <= {sig_window[WIN_W-17:0], ioctl.dout[7:0], ioctl.dout[15:8]};
	end

endmodule

//--- logic/quirk_match.sv
// Title quirk lookup
// Captures the 12 byte header title and flags games needing save or remap fixes

`timescale 1ns/10ps
`include "cart_loader_params.svh"

module quirk_match (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  cart_loader_pkg::ioctl_bus_s ioctl,
	input  cart_loader_pkg::dl_kind_e   dl_kind,
	input  logic                        cart_start,
	output logic                        sram_quirk,
	output logic                        memory_remap
);

	localparam int QUIRK_COUNT = 20;

	// ==============================
	// Title table, zero padded
	// ==============================
	localparam cart_loader_pkg::cart_id_t QUIRK_TITLES [QUIRK_COUNT] = '{
		"ROCKY BOXING",
		{"ROCKY", 56'h0},
		"DBZ LGCYGOKU",
		"DRAGONBALL Z",
		"DBZ TAIKETSU",
		"DRAGON BALLZ",
		{"TOPGUN CZ", 24'h0},
		{"IRIDIONII", 24'h0},
		{"BOMBER MAN", 16'h0},       // NES classics from here on
		{"CASTLEVANIA", 8'h0},
		{"DONKEY KONG", 8'h0},
		{"DR. MARIO", 24'h0},
		{"EXCITEBIKE", 16'h0},
		{"ICE CLIMBER", 8'h0},
		{"NES METROID", 8'h0},
		{"PAC-MAN", 40'h0},
		{"SUPER MARIO", 8'h0},
		{"ZELDA 1", 40'h0},
		{"XEVIOUS", 40'h0},
		{"NES ZELDA 2", 8'h0}
	};
	// Entries 8 and up also need the memory remap
	localparam logic [QUIRK_COUNT-1:0] REMAP_MASK = 20'hFFF00;

	cart_loader_pkg::cart_id_t cart_id;
	logic       cart_wr;
	logic       in_id_line;     // Write lands in header line 0xA0..0xAF
	logic [3:0] id_offset;
	logic [6:0] id_lsb;         // Bit position of this halfword in cart_id
	logic       title_hit;
	logic       remap_hit;

	assign cart_wr    = ioctl.wr && (dl_kind == cart_loader_pkg::DL_CART);
	assign in_id_line = ioctl.addr[`CL_ADDR_W-1:4] == `CL_ID_LINE;
	assign id_offset  = ioctl.addr[3:0];
	assign id_lsb     = 7'(((`CL_ID_LEN - 2) - id_offset) * 8);

	always_comb begin
		title_hit = 1'b0;
		remap_hit = 1'b0;
		for (int i = 0; i < QUIRK_COUNT; i++) begin
			if (cart_id == QUIRK_TITLES[i]) begin
				title_hit = 1'b1;
				remap_hit = remap_hit | REMAP_MASK[i];
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			sram_quirk   <= 1'b0;
			memory_remap <= 1'b0;
		end else if (cart_start) begin
			sram_quirk   <= 1'b0;
			memory_remap <= 1'b0;
		end else if (cart_wr && in_id_line && (id_offset == `CL_ID_LEN)) begin
			sram_quirk   <= sram_quirk | title_hit;    // Title complete at 0xAC
			memory_remap <= memory_remap | remap_hit;
		end

		// Swap bytes so the first character sits at the top
		if (cart_wr && in_id_line && (id_offset < `CL_ID_LEN))
			cart_id[id_lsb +: 16] <= {ioctl.dout[7:0], ioctl.dout[15:8]};
	end

endmodule

//--- logic/rom_write_port.sv
// Cartridge ROM write port
// Places cart halfwords in the ROM area of external memory and
// stalls the host until each write is acknowledged

`timescale 1ns/10ps
`include "cart_loader_params.svh"

module rom_write_port (
	input  logic                        clk_sys,
	input  logic                        reset,
	input  cart_loader_pkg::ioctl_bus_s ioctl,
	input  cart_loader_pkg::dl_kind_e   dl_kind,
	output cart_loader_pkg::rom_write_s rom,
	input  logic                        rom_ack,
	output logic                        ioctl_wait
);

	localparam cart_loader_pkg::rom_addr_t ROM_BASE = cart_loader_pkg::rom_addr_t'(`CL_ROM_START_HW);

	logic is_cart;
	logic cart_wr;
	logic wait_q;     // A write is out to memory

	assign is_cart = dl_kind == cart_loader_pkg::DL_CART;
	assign cart_wr = ioctl.wr && is_cart;

	// Drop the stall at once when the cart download goes away
	assign ioctl_wait = wait_q && is_cart;

	// ==============================
	// Request and stall
	// ==============================
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			rom.req <= 1'b0;
			wait_q  <= 1'b0;
		end else begin
			rom.req <= cart_wr;                        // Same cycle as the stall rises
			if (!is_cart)     wait_q <= 1'b0;
			else if (rom_ack) wait_q <= 1'b0;          // Released the cycle after ack
			else if (cart_wr) wait_q <= 1'b1;
		end

		if (cart_wr) begin
			rom.addr <= ioctl.addr[`CL_ADDR_W-1:1] + ROM_BASE;  // Halfword units
			rom.data <= ioctl.dout;
		end
	end

endmodule

//--- run_sim.sh
#!/bin/sh
# Build and run the cart loader testbench with Verilator
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module cart_loader_tb -f src.f
./obj_dir/Vcart_loader_tb +verilator+error+limit+1000 > sim.log 2>&1 || true
cat sim.log
if grep -qx "ALL CHECKS PASSED" sim.log; then
	exit 0
fi
echo "Simulation did not pass, see sim.log"
exit 1

//--- src.f
+incdir+logic
logic/cart_loader_pkg.sv
logic/download_decode.sv
logic/flash_sig_scan.sv
logic/quirk_match.sv
logic/bios_word_packer.sv
logic/rom_write_port.sv
logic/cart_loader_top.sv
testbench/cart_loader_asserts.sv
testbench/cart_loader_tb.sv

//--- testbench/cart_loader_asserts.sv
// Cart loader protocol assertions
// Bound into the top level, watches requests, stall and strobes

`timescale 1ns/10ps

module cart_loader_asserts (
	input logic                      clk_sys,
	input logic                      reset,
	input cart_loader_pkg::dl_kind_e dl_kind,
	input logic                      ioctl_wr,
	input logic                      ioctl_wait,
	input logic                      rom_req,
	input logic                      bios_wr
);

	int fail_count = 0;   // Tally read back by the testbench

	ap_req_in_cart: assert property (@(posedge clk_sys) disable iff (reset)
		rom_req |-> dl_kind == cart_loader_pkg::DL_CART)
	else begin
		fail_count++;
		$error("rom.req outside a cart download");
	end

	// Every cart write is followed by a request with the stall up
	ap_wait_after_wr: assert property (@(posedge clk_sys) disable iff (reset)
		ioctl_wr && dl_kind == cart_loader_pkg::DL_CART |=> rom_req && ioctl_wait)
	else begin
		fail_count++;
		$error("no request with ioctl_wait after a cart write");
	end

	ap_bios_pulse: assert property (@(posedge clk_sys) disable iff (reset)
		bios_wr |=> !bios_wr)
	else begin
		fail_count++;
		$error("bios.wr held for two cycles");
	end

	ap_no_wr_stalled: assert property (@(posedge clk_sys) disable iff (reset)
		!(ioctl_wr && ioctl_wait))   // Host must hold off
	else begin
		fail_count++;
		$error("host write while ioctl_wait is high");
	end

endmodule

bind cart_loader_top cart_loader_asserts u_asserts (
	.clk_sys(clk_sys), .reset(reset), .dl_kind(dl_kind), .ioctl_wr(ioctl.wr),
	.ioctl_wait(ioctl_wait), .rom_req(rom.req), .bios_wr(bios.wr)
);

//--- testbench/cart_loader_cases.txt
# kind(0 bios 1 cart) index(hex) start(hex) words(dec) flash sram remap turbo max_pak(hex)
# then the 16 bit words in hex, the low byte belongs to the even address
0 00 0000 4 0 0 0 0 0
1234 5678 9abc def0
1 01 00a0 12 1 1 0 0 2d
4244 205a 4154 4b49 5445 5553 0000
4c46 5341 3148 5f4d 0056
1 40 00a0 12 1 1 1 1 2d
4150 2d43 414d 004e 0000 0000 0000
4600 414c 4853 4d31 565f
1 81 00a0 8 0 0 0 1 2b
4548 4c4c 204f 4f57 4c52 2144 0000 1111
1 c2 2000 5 0 0 0 1 802
4c46 5341 3148 5f4d 0057
0 00 7ff8 4 0 0 0 1 802
aabb ccdd eeff 0011

//--- testbench/cart_loader_tb.sv
// Cart loader testbench
// Replays host downloads from the cases file, answers ROM writes with a
// random delay memory and checks strobes and cart properties

`timescale 1ns/10ps
`include "cart_loader_params.svh"

module cart_loader_tb;

	localparam int TIMEOUT = 100;   // Cycles allowed for any one wait
	localparam int PERIOD  = 100;   // Clock period in ns

	logic                         clk_sys;
	logic                         reset;
	cart_loader_pkg::ioctl_bus_s  ioctl;
	logic                         ioctl_download;
	logic [7:0]                   ioctl_index;
	logic                         ioctl_wait;
	cart_loader_pkg::bios_write_s bios;
	cart_loader_pkg::rom_write_s  rom;
	logic                         rom_ack;
	cart_loader_pkg::cart_info_s  cart_info;

	logic [15:0] lfsr = 16'd43634;  // Memory delay source
	logic [15:0] bios_low;          // Low half of the BIOS word being built
	int          req_count;
	int          bios_count;
	time         ack_time;          // When the last rom_ack was raised

	cart_loader_top dut (.*);

	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD / 2) clk_sys = ~clk_sys;
	end

	// Galois LFSR, taps 16 14 13 11
	function automatic logic [15:0] lfsr_step(input logic [15:0] state);
		return state[0] ? ((state >> 1) ^ 16'hB400) : (state >> 1);
	endfunction

	task automatic check_value(input string name, input logic [63:0] got,
		input logic [63:0] exp);
		if (got !== exp) begin
			$display("CHECK FAILED at %0t: %s is %0h, expected %0h", $time, name, got, exp);
			$display("CHECKS FAILED");
			$fatal(1, "Stopped on %s", name);
		end
	endtask

	task automatic stop_run(input string why);
		$display("Error at %0t: %s", $time, why);
		$display("CHECKS FAILED");
		$fatal(1, "Stopped: %s", why);
	endtask

	// ==============================
	// Memory model and strobe counters
	// ==============================
	always begin
		logic [2:0] delay;
		@(negedge clk_sys);
		if (rom.req) begin
			req_count++;
			for (int b = 0; b < 3; b++) begin
				lfsr  = lfsr_step(lfsr);           // One step per delay bit
				delay = {delay[1:0], lfsr[0]};
			end
			repeat (delay) @(negedge clk_sys);
			rom_ack  = 1'b1;                        // Single cycle acknowledge
			ack_time = $time;
			@(negedge clk_sys);
			rom_ack = 1'b0;
		end
	end

	always @(negedge clk_sys) begin
		if (bios.wr) bios_count++;
	end

	// Stop at the first protocol assertion failure
	always @(negedge clk_sys) begin
		if (dut.u_asserts.fail_count != 0) stop_run("a protocol assertion failed");
	end

	// One host halfword write and the loader's answer to it
	task automatic host_write(input logic is_cart, input logic [26:0] addr,
		input logic [15:0] data);
		int cycles;
		ioctl = '{addr: addr, dout: data, wr: 1'b1};
		@(negedge clk_sys);
		ioctl.wr = 1'b0;
		cycles = 0;
		if (is_cart) begin
			while (!rom.req) begin
				@(negedge clk_sys);
				cycles++;
				if (cycles > TIMEOUT) stop_run("no rom.req after a cart write");
			end
			check_value("rom.addr", rom.addr, 64'(addr >> 1) + `CL_ROM_START_HW);
			check_value("rom.data", rom.data, data);
			check_value("ioctl_wait", ioctl_wait, 1'b1);   // Stall rises with the request
			cycles = 0;
			while (ioctl_wait) begin
				@(negedge clk_sys);
				cycles++;
				if (cycles > TIMEOUT) stop_run("ioctl_wait never fell after a cart write");
			end
			// Stall drops one cycle after the acknowledge and not before
			check_value("ioctl_wait fall after rom_ack", $time - ack_time, PERIOD);
		end else if (addr[1]) begin
			while (!bios.wr) begin
				@(negedge clk_sys);
				cycles++;
				if (cycles > TIMEOUT) stop_run("no bios.wr after the upper halfword");
			end
			check_value("bios.addr", bios.addr, addr[13:2]);
			check_value("bios.data", bios.data, {data, bios_low});
		end else begin
			bios_low = data;
		end
	endtask

	initial begin
		int    fd;
		int    kind, index, start, count, word;
		int    exp_flash, exp_sram, exp_remap, exp_turbo, exp_max;
		int    records;
		string line;
		ioctl          = '0;
		ioctl_download = 1'b0;
		ioctl_index    = 8'd0;
		rom_ack        = 1'b0;
		reset          = 1'b1;
		records        = 0;
		repeat (4) @(negedge clk_sys);
		reset = 1'b0;
		@(negedge clk_sys);
		check_value("ioctl_wait", ioctl_wait, 1'b0);
		check_value("rom.req", rom.req, 1'b0);
		check_value("bios.wr", bios.wr, 1'b0);
		check_value("cart_info", cart_info, 0);

		fd = $fopen("testbench/cart_loader_cases.txt", "r");
		if (fd == 0) stop_run("cannot open the cases file");
		void'($fgets(line, fd));     // Two column description lines
		void'($fgets(line, fd));
		while ($fscanf(fd, "%d %h %h %d %d %d %d %d %h", kind, index, start, count,
			exp_flash, exp_sram, exp_remap, exp_turbo, exp_max) == 9) begin
			ioctl_index    = index[7:0];
			ioctl_download = 1'b1;
			repeat (2) @(negedge clk_sys);   // Kind settles before the first write
			req_count  = 0;
			bios_count = 0;
			for (int i = 0; i < count; i++) begin
				if ($fscanf(fd, "%h", word) != 1) stop_run("cases file ends inside a record");
				host_write(kind == 1, 27'(start + 2 * i), word[15:0]);
			end
			ioctl_download = 1'b0;
			repeat (3) @(negedge clk_sys);   // Kind drops and the end address is latched
			check_value("rom.req count", req_count, kind == 1 ? count : 0);
			check_value("bios.wr count", bios_count, kind == 1 ? 0 : count / 2);
			check_value("flash_1m", cart_info.flash_1m, exp_flash);
			check_value("sram_quirk", cart_info.sram_quirk, exp_sram);
			check_value("memory_remap", cart_info.memory_remap, exp_remap);
			check_value("force_turbo", cart_info.force_turbo, exp_turbo);
			check_value("max_pak_addr", cart_info.max_pak_addr, exp_max);
			records++;
		end
		$fclose(fd);

		if (records > 0 && dut.u_asserts.fail_count == 0) begin
			$display("ALL CHECKS PASSED");
			$finish;
		end else begin
			$display("%0d records run, %0d assertion failures", records,
				dut.u_asserts.fail_count);
			$display("CHECKS FAILED");
			$fatal(1, "Run failed");
		end
	end

endmodule
